// File: hdl/tcdm_pkg.sv
// ---------------------------------------------------------------------------
// TCDM adapter package
// Word and address widths, atomic opcodes and the request structs shared
// by the bank adapter blocks
// ---------------------------------------------------------------------------

package tcdm_pkg;

  // Memory word, fixed at one 32-bit word
  localparam int unsigned DataWidth = 32;
  // Byte address toward the bank
  localparam int unsigned AddrWidth = 32;
  // One enable per data byte
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ---------------------------------------------------------------------------
  // Atomic opcodes
  // ---------------------------------------------------------------------------
  // Codes 4'hA to 4'hF carry no atomic and behave like 4'h0
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9
  } amo_op_e;

  // ---------------------------------------------------------------------------
  // Request structs
  // ---------------------------------------------------------------------------
  // Incoming request on the valid/ready side
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    amo_op_e              amo;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } tcdm_req_t;

  // Command toward the SRAM, qualified by the request strobe
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } mem_req_t;

endpackage

// File: hdl/amo_alu.sv
// ---------------------------------------------------------------------------
// Atomic ALU
// Computes the new memory word from the old word and the request operand,
// one shared 33-bit adder serves add and all four comparisons
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module amo_alu (
  input  tcdm_pkg::amo_op_e              op_i,
  input  logic [tcdm_pkg::DataWidth-1:0] mem_i,
  input  logic [tcdm_pkg::DataWidth-1:0] operand_i,
  output logic [tcdm_pkg::DataWidth-1:0] result_o
);

  import tcdm_pkg::*;

  // Adder inputs carry one extra bit for sign or zero extension
  logic [DataWidth:0] add_a;
  logic [DataWidth:0] add_b;
  logic [DataWidth:0] add_sum;

  // Operand selection for the shared adder
  always_comb begin
    // Add uses both words sign extended
    add_a = {mem_i[DataWidth-1], mem_i};
    add_b = {operand_i[DataWidth-1], operand_i};
    case (op_i)
      // Signed compare as mem minus operand
      AmoMax, AmoMin: begin
        add_b = -{operand_i[DataWidth-1], operand_i};
      end
      // Unsigned compare with zero extension
      AmoMaxu, AmoMinu: begin
        add_a = {1'b0, mem_i};
        add_b = -{1'b0, operand_i};
      end
      default: ;
    endcase
  end

  assign add_sum = add_a + add_b;

  // Result selection, the top sum bit is set when mem is below operand
  always_comb begin
    // Swap and plain accesses pass the operand on
    result_o = operand_i;
    case (op_i)
      AmoAdd:  result_o = add_sum[DataWidth-1:0];
      AmoAnd:  result_o = mem_i & operand_i;
      AmoOr:   result_o = mem_i | operand_i;
      AmoXor:  result_o = mem_i ^ operand_i;
      AmoMax,
      AmoMaxu: result_o = add_sum[DataWidth] ? operand_i : mem_i;
      AmoMin,
      AmoMinu: result_o = add_sum[DataWidth] ? mem_i : operand_i;
      default: ;
    endcase
  end

endmodule

// File: hdl/resp_slot.sv
// ---------------------------------------------------------------------------
// Response slot
// Holds one response payload until it is taken, as a two-entry spill
// register or as a single-entry fall-through register
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module resp_slot #(
  parameter type T           = logic,
  parameter bit  FallThrough = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (FallThrough) begin : gen_fall_through
    // -------------------------------------------------------------------------
    // Single entry, input visible at the output in the same cycle
    // -------------------------------------------------------------------------
    logic full_q;
    T     data_q;

    // Only an empty slot takes new data
    assign ready_o = ~full_q;
    assign valid_o = full_q | valid_i;
    // Stored entry has priority over the incoming one
    assign data_o  = full_q ? data_q : data_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        full_q <= 1'b0;
      end else if (full_q) begin
        // Leaves once the downstream takes it
        full_q <= ~ready_i;
      end else begin
        // Keep the input only if it was not taken right away
        full_q <= valid_i & ~ready_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!full_q && valid_i && !ready_i) begin
        data_q <= data_i;
      end
    end
  end else begin : gen_spill
    // -------------------------------------------------------------------------
    // Two entries, one cycle from input to output
    // -------------------------------------------------------------------------
    logic a_full_q, b_full_q;
    T     a_data_q, b_data_q;
    logic a_fill, a_drain;
    logic b_fill, b_drain;

    // Stage A takes input, stage B catches A when the output stalls
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    assign ready_o = ~a_full_q | ~b_full_q;
    assign valid_o = a_full_q | b_full_q;
    // Stage B is always the older entry
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) a_full_q <= a_fill;
        if (b_fill || b_drain) b_full_q <= b_fill;
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= data_i;
      if (b_fill) b_data_q <= a_data_q;
    end
  end

endmodule

// File: hdl/adapter_ctrl.sv
// ---------------------------------------------------------------------------
// Adapter control
// Accepts requests, steers the SRAM port and runs the read-modify-write
// sequence of the atomics
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module adapter_ctrl #(
  // Registers the ALU result, one extra cycle per atomic
  parameter bit RegisterAmo = 1'b0
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Request side
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  tcdm_pkg::tcdm_req_t            in_req_i,
  // Response valid but not yet taken
  input  logic                           resp_pending_i,
  // Strobes toward the two response slots
  output logic                           meta_push_o,
  output logic                           rdata_capture_o,
  // Atomic ALU
  output tcdm_pkg::amo_op_e              amo_op_o,
  output logic [tcdm_pkg::DataWidth-1:0] amo_operand_o,
  input  logic [tcdm_pkg::DataWidth-1:0] amo_result_i,
  // SRAM side
  output logic                           out_req_o,
  output tcdm_pkg::mem_req_t             out_cmd_o
);

  import tcdm_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    DoAmo,
    WriteBack
  } state_e;

  state_e state_q, state_d;

  // Handshake and access qualifiers
  logic req_accepted;
  logic is_amo;
  logic amo_wb;
  logic capture_q;

  // Operands of the atomic in flight
  amo_op_e              amo_op_q;
  logic [AddrWidth-1:0] addr_q;
  logic [DataWidth-1:0] operand_q;
  logic [DataWidth-1:0] wb_data;

  // ---------------------------------------------------------------------------
  // Request acceptance
  // ---------------------------------------------------------------------------
  // Blocked while an atomic owns the port or a response waits
  assign in_ready_o   = (state_q == Idle) & ~resp_pending_i;
  assign req_accepted = in_valid_i & in_ready_o;
  // Unused codes fall back to plain loads and stores
  assign is_amo = in_req_i.amo inside {AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor,
                                       AmoMax, AmoMaxu, AmoMin, AmoMinu};

  // Metadata enters its slot in the acceptance cycle
  assign meta_push_o = req_accepted;

  // Cycles in which the SRAM port carries the atomic write
  assign amo_wb = (state_q == WriteBack) | ((state_q == DoAmo) & ~RegisterAmo);

  // ---------------------------------------------------------------------------
  // SRAM port steering
  // ---------------------------------------------------------------------------
  always_comb begin
    // Request passes straight through when idle
    out_req_o       = req_accepted | amo_wb;
    out_cmd_o.addr  = in_req_i.addr;
    out_cmd_o.write = in_req_i.write;
    out_cmd_o.wdata = in_req_i.wdata;
    out_cmd_o.be    = in_req_i.be;
    if (amo_wb) begin
      // Full word write of the atomic result
      out_cmd_o.addr  = addr_q;
      out_cmd_o.write = 1'b1;
      out_cmd_o.wdata = wb_data;
      out_cmd_o.be    = '1;
    end
  end

  // ---------------------------------------------------------------------------
  // Atomic FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Read of the old word happens on acceptance
      Idle:      if (req_accepted && is_amo) state_d = DoAmo;
      // Old word arrives here, write now or one cycle later
      DoAmo:     state_d = RegisterAmo ? WriteBack : Idle;
      WriteBack: state_d = Idle;
      default:   state_d = Idle;
    endcase
  end

  // Optional result register between ALU and write port
  if (RegisterAmo) begin : gen_result_reg
    logic [DataWidth-1:0] result_q;

    always_ff @(posedge clk_i) begin
      if (state_q == DoAmo) result_q <= amo_result_i;
    end

    assign wb_data = result_q;
  end else begin : gen_result_direct
    assign wb_data = amo_result_i;
  end

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

  // Read data shows up one cycle after a request, never after a write-back
  assign rdata_capture_o = capture_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      capture_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      capture_q <= out_req_o & ~amo_wb;
    end
  end

  // Operands kept for the write-back
  always_ff @(posedge clk_i) begin
    if (req_accepted && is_amo) begin
      amo_op_q  <= in_req_i.amo;
      addr_q    <= in_req_i.addr;
      operand_q <= in_req_i.wdata;
    end
  end

endmodule

// File: hdl/tcdm_adapter.sv
// ---------------------------------------------------------------------------
// TCDM bank adapter
// Converts a valid/ready request stream into SRAM strobes, returns each
// response with its metadata and performs atomics on the bank
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module tcdm_adapter #(
  parameter type meta_t      = logic,
  parameter bit  RegisterAmo = 1'b0
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Request side
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  tcdm_pkg::tcdm_req_t            in_req_i,
  input  meta_t                          in_meta_i,
  // Response side
  output logic                           in_valid_o,
  input  logic                           in_ready_i,
  output logic [tcdm_pkg::DataWidth-1:0] in_rdata_o,
  output meta_t                          in_meta_o,
  // SRAM side
  output logic                           out_req_o,
  output tcdm_pkg::mem_req_t             out_cmd_o,
  input  logic [tcdm_pkg::DataWidth-1:0] out_rdata_i
);

  import tcdm_pkg::*;

  // Slot strobes and status
  logic meta_push, rdata_capture;
  logic meta_valid, rdata_valid;
  logic resp_accepted, resp_pending;

  // Atomic ALU connections
  amo_op_e              amo_op;
  logic [DataWidth-1:0] amo_operand;
  logic [DataWidth-1:0] amo_result;

  // Response needs both parts, read data is always the later one
  assign in_valid_o    = meta_valid & rdata_valid;
  assign resp_accepted = in_valid_o & in_ready_i;
  assign resp_pending  = in_valid_o & ~in_ready_i;

  adapter_ctrl #(
    .RegisterAmo(RegisterAmo)
  ) i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_req_i       (in_req_i),
    .resp_pending_i (resp_pending),
    .meta_push_o    (meta_push),
    .rdata_capture_o(rdata_capture),
    .amo_op_o       (amo_op),
    .amo_operand_o  (amo_operand),
    .amo_result_i   (amo_result),
    .out_req_o      (out_req_o),
    .out_cmd_o      (out_cmd_o)
  );

  // Old memory word straight from the SRAM
  amo_alu i_amo_alu (
    .op_i     (amo_op),
    .mem_i    (out_rdata_i),
    .operand_i(amo_operand),
    .result_o (amo_result)
  );

  // Metadata waits a cycle for its read data
  resp_slot #(
    .T          (meta_t),
    .FallThrough(1'b0)
  ) i_meta_slot (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(meta_push),
    .ready_o(),
    .data_i (in_meta_i),
    .valid_o(meta_valid),
    .ready_i(resp_accepted),
    .data_o (in_meta_o)
  );

  // Read data only stored if the response stalls
  resp_slot #(
    .T          (logic [DataWidth-1:0]),
    .FallThrough(1'b1)
  ) i_rdata_slot (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(rdata_capture),
    .ready_o(),
    .data_i (out_rdata_i),
    .valid_o(rdata_valid),
    .ready_i(resp_accepted),
    .data_o (in_rdata_o)
  );

endmodule

// File: testbench/tb_tcdm_adapter.sv
// ---------------------------------------------------------------------------
// TCDM adapter testbench
// Runs both RegisterAmo variants against a behavioral SRAM and a reference
// memory, with directed atomics, back-pressure and a random mix
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_tcdm_adapter;

  import tcdm_pkg::*;

  localparam int Timeout = 100;
  localparam int Words   = 64;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [7:0]           meta;
    logic                 check;
  } exp_t;

  logic clk_i;
  logic rst_ni;

  // Per-DUT stimulus and responses, index 0 plain, index 1 registered ALU
  logic                 valid_s[2];
  tcdm_req_t            req_s[2];
  logic [7:0]           meta_s[2];
  logic                 ready_s[2];
  logic                 ready_o_s[2];
  logic                 valid_o_s[2];
  logic [DataWidth-1:0] rdata_o_s[2];
  logic [7:0]           meta_o_s[2];
  logic                 mreq_s[2];
  mem_req_t             mcmd_s[2];
  logic [DataWidth-1:0] mrdata_s[2];

  logic [DataWidth-1:0] sram[2][Words];
  logic [DataWidth-1:0] ref_mem[2][Words];
  exp_t                 exp_q[$];

  int         active;
  int         bp_mode;
  int         seed;
  logic [7:0] tag_cnt;

  tcdm_adapter #(
    .meta_t     (logic [7:0]),
    .RegisterAmo(1'b0)
  ) i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (valid_s[0]),
    .in_ready_o (ready_o_s[0]),
    .in_req_i   (req_s[0]),
    .in_meta_i  (meta_s[0]),
    .in_valid_o (valid_o_s[0]),
    .in_ready_i (ready_s[0]),
    .in_rdata_o (rdata_o_s[0]),
    .in_meta_o  (meta_o_s[0]),
    .out_req_o  (mreq_s[0]),
    .out_cmd_o  (mcmd_s[0]),
    .out_rdata_i(mrdata_s[0])
  );

  tcdm_adapter #(
    .meta_t     (logic [7:0]),
    .RegisterAmo(1'b1)
  ) i_dut_reg (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (valid_s[1]),
    .in_ready_o (ready_o_s[1]),
    .in_req_i   (req_s[1]),
    .in_meta_i  (meta_s[1]),
    .in_valid_o (valid_o_s[1]),
    .in_ready_i (ready_s[1]),
    .in_rdata_o (rdata_o_s[1]),
    .in_meta_o  (meta_o_s[1]),
    .out_req_o  (mreq_s[1]),
    .out_cmd_o  (mcmd_s[1]),
    .out_rdata_i(mrdata_s[1])
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Fill pattern over the whole word index
  function automatic logic [DataWidth-1:0] fill_word(input int idx);
    return 32'hc3a5_0f00 ^ (idx * 32'h0101_0101) ^ (idx << 20);
  endfunction

  // ---------------------------------------------------------------------------
  // Behavioral SRAM, one cycle read latency, read before write
  // ---------------------------------------------------------------------------
  initial begin
    for (int k = 0; k < 2; k++) mrdata_s[k] = '0;
    forever begin
      @(posedge clk_i);
      for (int k = 0; k < 2; k++) begin
        if (!rst_ni) begin
          for (int i = 0; i < Words; i++) sram[k][i] <= fill_word(i);
        end else if (mreq_s[k]) begin
          mrdata_s[k] <= sram[k][mcmd_s[k].addr[7:2]];
          if (mcmd_s[k].write) begin
            for (int b = 0; b < BeWidth; b++) begin
              if (mcmd_s[k].be[b]) sram[k][mcmd_s[k].addr[7:2]][8*b+:8] <= mcmd_s[k].wdata[8*b+:8];
            end
          end
        end else begin
          // Read data is only valid in the cycle after a request
          mrdata_s[k] <= ~mrdata_s[k];
        end
      end
    end
  end

  // Response ready, 0 always ready, 1 held low, 2 random
  always begin
    logic [31:0] rnd;
    logic        rdy;
    rdy = (bp_mode == 0);
    if (bp_mode == 2) begin
      rnd = $random(seed);
      rdy = rnd[0] | rnd[1];
    end
    ready_s[0] = rdy;
    ready_s[1] = rdy;
    @(posedge clk_i);
    #1;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("** Error at %0t: %s", $time, what);
    $display("tests failed");
    $fatal(1);
  endtask

  // RISC-V AMO rules on old word a and operand b
  function automatic logic [31:0] amo_ref(input amo_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      AmoSwap: return b;
      AmoAdd:  return a + b;
      AmoAnd:  return a & b;
      AmoOr:   return a | b;
      AmoXor:  return a ^ b;
      AmoMax:  return ($signed(a) > $signed(b)) ? a : b;
      AmoMaxu: return (a > b) ? a : b;
      AmoMin:  return ($signed(a) < $signed(b)) ? a : b;
      AmoMinu: return (a < b) ? a : b;
      default: return b;
    endcase
  endfunction

  function automatic tcdm_req_t make_req(input int word, input logic [3:0] amo,
                                         input logic write, input logic [31:0] wdata,
                                         input logic [3:0] be);
    tcdm_req_t r;
    r.addr  = {24'd0, word[5:0], 2'b00};
    r.amo   = amo_op_e'(amo);
    r.write = write;
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // Response checker on the active DUT
  // ---------------------------------------------------------------------------
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_ni && valid_o_s[active] && ready_s[active]) begin
      if (exp_q.size() == 0) report_failure("response arrived without a request");
      e = exp_q.pop_front();
      assert (meta_o_s[active] == e.meta)
        else report_mismatch("in_meta_o", {24'd0, meta_o_s[active]}, {24'd0, e.meta});
      if (e.check) begin
        assert (rdata_o_s[active] == e.data)
          else report_mismatch("in_rdata_o", rdata_o_s[active], e.data);
      end
    end
  end

  // Returns after the acceptance cycle with valid already dropped
  task automatic send_req(input tcdm_req_t req);
    int          waited;
    int          w;
    exp_t        e;
    logic [31:0] old;
    waited = 0;
    @(posedge clk_i);
    #1;
    valid_s[active] = 1'b1;
    req_s[active]   = req;
    meta_s[active]  = tag_cnt;
    @(negedge clk_i);
    while (!ready_o_s[active]) begin
      waited++;
      if (waited > Timeout) report_failure("request was not accepted in time");
      @(negedge clk_i);
    end
    w       = req.addr[7:2];
    old     = ref_mem[active][w];
    e.data  = old;
    e.meta  = tag_cnt;
    e.check = 1'b1;
    if (req.amo >= AmoSwap && req.amo <= AmoMinu) begin
      ref_mem[active][w] = amo_ref(req.amo, old, req.wdata);
    end else if (req.write) begin
      // Store response data is not defined
      e.check = 1'b0;
      for (int b = 0; b < BeWidth; b++) begin
        if (req.be[b]) ref_mem[active][w][8*b+:8] = req.wdata[8*b+:8];
      end
    end
    exp_q.push_back(e);
    tag_cnt = tag_cnt + 8'd1;
    @(posedge clk_i);
    #1;
    valid_s[active] = 1'b0;
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > Timeout) report_failure("responses did not drain in time");
      @(negedge clk_i);
    end
  endtask

  task automatic set_bp(input int mode);
    @(negedge clk_i);
    bp_mode = mode;
  endtask

  // Write-back port and handshake shape around one atomic
  task automatic check_amo_timing(input int word);
    send_req(make_req(word, 4'h2, 1'b0, 32'h0000_0101, 4'h0));
    @(negedge clk_i);
    assert (valid_o_s[active]) else report_mismatch("in_valid_o", 0, 1);
    assert (!ready_o_s[active]) else report_mismatch("in_ready_o", 1, 0);
    if (active == 1) begin
      assert (!mreq_s[active]) else report_mismatch("out_req_o", 1, 0);
      @(negedge clk_i);
      assert (!ready_o_s[active]) else report_mismatch("in_ready_o", 1, 0);
    end
    assert (mreq_s[active]) else report_mismatch("out_req_o", 0, 1);
    assert (mcmd_s[active].write) else report_mismatch("out_cmd_o.write", 0, 1);
    assert (mcmd_s[active].be == 4'hf)
      else report_mismatch("out_cmd_o.be", {28'd0, mcmd_s[active].be}, 32'hf);
    assert (mcmd_s[active].addr[7:2] == word[5:0])
      else report_mismatch("out_cmd_o.addr", mcmd_s[active].addr, {24'd0, word[5:0], 2'b00});
    drain();
  endtask

  // Held response stays put and blocks the SRAM port
  task automatic check_backpressure;
    int          waited;
    logic [31:0] held_data;
    logic [7:0]  held_meta;
    tcdm_req_t   next_req;
    waited   = 0;
    next_req = make_req(8, 4'h0, 1'b0, 32'h0, 4'h0);
    set_bp(1);
    send_req(make_req(7, 4'h0, 1'b0, 32'h0, 4'h0));
    // Second request waits while the first response is held
    valid_s[active] = 1'b1;
    req_s[active]   = next_req;
    meta_s[active]  = tag_cnt;
    while (!valid_o_s[active]) begin
      waited++;
      if (waited > Timeout) report_failure("response did not become valid");
      @(negedge clk_i);
    end
    held_data = rdata_o_s[active];
    held_meta = meta_o_s[active];
    repeat (5) begin
      @(negedge clk_i);
      assert (valid_o_s[active]) else report_mismatch("in_valid_o", 0, 1);
      assert (rdata_o_s[active] == held_data)
        else report_mismatch("in_rdata_o", rdata_o_s[active], held_data);
      assert (meta_o_s[active] == held_meta)
        else report_mismatch("in_meta_o", {24'd0, meta_o_s[active]}, {24'd0, held_meta});
      assert (!ready_o_s[active]) else report_mismatch("in_ready_o", 1, 0);
      assert (!mreq_s[active]) else report_mismatch("out_req_o", 1, 0);
    end
    set_bp(0);
    // Waiting request goes through once the held response is taken
    send_req(next_req);
    drain();
  endtask

  task automatic run_suite;
    logic [31:0] rnd;
    logic [31:0] data;
    logic [3:0]  amo;
    // Byte enables on a store, then read back
    send_req(make_req(3, 4'h0, 1'b1, 32'h1122_3344, 4'b0101));
    send_req(make_req(3, 4'h0, 1'b0, 32'h0, 4'h0));
    send_req(make_req(4, 4'hb, 1'b1, 32'hcafe_f00d, 4'hf));
    send_req(make_req(4, 4'hb, 1'b0, 32'h0, 4'h0));
    drain();
    // Every atomic opcode followed by a load
    for (int op = 1; op <= 9; op++) begin
      data = $random(seed);
      send_req(make_req(8 + op, op[3:0], 1'b0, data, 4'h0));
      send_req(make_req(8 + op, 4'h0, 1'b0, 32'h0, 4'h0));
    end
    drain();
    check_amo_timing(20);
    check_backpressure();
    // Random mix on a few words so accesses collide
    set_bp(2);
    repeat (60) begin
      rnd  = $random(seed);
      data = $random(seed);
      amo  = (rnd[7:4] > 4'h9) ? 4'h0 : rnd[7:4];
      if (rnd[11:8] == 4'hf) amo = 4'hb;
      send_req(make_req(rnd[3:0], amo, rnd[12], data, rnd[19:16]));
    end
    drain();
    set_bp(0);
  endtask

  initial begin
    seed    = 32'hda97;
    bp_mode = 0;
    active  = 0;
    tag_cnt = 8'd0;
    rst_ni  = 1'b0;
    for (int k = 0; k < 2; k++) begin
      valid_s[k] = 1'b0;
      req_s[k]   = '0;
      meta_s[k]  = '0;
      for (int i = 0; i < Words; i++) ref_mem[k][i] = fill_word(i);
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Idle state after reset on both variants
    for (int k = 0; k < 2; k++) begin
      assert (!valid_o_s[k]) else report_mismatch("in_valid_o", 1, 0);
      assert (!mreq_s[k]) else report_mismatch("out_req_o", 1, 0);
      assert (ready_o_s[k]) else report_mismatch("in_ready_o", 0, 1);
    end
    run_suite();
    active = 1;
    run_suite();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: project.f
hdl/tcdm_pkg.sv
hdl/amo_alu.sv
hdl/resp_slot.sv
hdl/adapter_ctrl.sv
hdl/tcdm_adapter.sv
testbench/tb_tcdm_adapter.sv

// File: run.sh
#!/bin/sh
# Build and run the TCDM adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module tb_tcdm_adapter \
  -f project.f \
  -o sim

status=0
out=$(./obj_dir/sim) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "simulation exit status $status"
exit 1
